/* rtl/id_macros.svh */
// widths and fixed encodings for the RV64 decode stage; XLEN is fixed at 64, not a free parameter
`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

// data path and pc width
`define ID_XLEN 64

// fetched instruction width, no compressed encodings
`define ID_INST_W 32

// register index width, 32 architectural registers
`define ID_GPR_AW 5

// addi x0, x0, 0
`define ID_NOP_INST 32'h00000013

`endif

/* rtl/isa_pkg.sv */
// encodings of the supported subset only (LUI ADDI ADD SUB LD SD, branches, JAL JALR)
`include "id_macros.svh"

package isa_pkg;

  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  typedef enum logic [1:0] {BR_NONE, BR_COND, BR_JAL, BR_JALR} br_kind_e;

  // values are funct3 of the branch encodings
  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } br_func_e;

  typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_PASS2} alu_op_e;

  typedef enum logic {SRC1_RS1, SRC1_PC} src1_sel_e;

  typedef enum logic [1:0] {SRC2_RS2, SRC2_IMM, SRC2_FOUR} src2_sel_e;

endpackage

/* rtl/pipe_pkg.sv */
// stage buses as packed structs; a bypass rd of zero means the stage carries no result
`include "id_macros.svh"

package pipe_pkg;
  import isa_pkg::*;

  typedef struct packed {
    logic [`ID_INST_W-1:0] inst;
    logic [`ID_XLEN-1:0]   pc;
  } fs_to_ds_t;

  typedef struct packed {
    logic                  wen;
    logic [`ID_GPR_AW-1:0] addr;
    logic [`ID_XLEN-1:0]   data;
  } rf_wr_t;

  typedef struct packed {
    logic [`ID_GPR_AW-1:0] rd;
    logic [`ID_XLEN-1:0]   result;
  } bypass_t;

  typedef struct packed {
    logic [`ID_GPR_AW-1:0] rs1;
    logic [`ID_GPR_AW-1:0] rs2;
    logic [`ID_GPR_AW-1:0] rd;
    logic [`ID_XLEN-1:0]   imm;
    alu_op_e               alu_op;
    src1_sel_e             src1_sel;
    src2_sel_e             src2_sel;
    logic                  gpr_wen;
    logic                  mem_ren;
    logic                  mem_wen;
    logic                  load_sel;
    br_kind_e              br_kind;
    br_func_e              br_func;
    logic                  invalid;
  } dec_ctrl_t;

  typedef struct packed {
    logic [`ID_XLEN-1:0]   rs1data;
    logic [`ID_XLEN-1:0]   rs2data;
    logic [`ID_XLEN-1:0]   imm;
    logic [`ID_XLEN-1:0]   pc;
    src1_sel_e             src1_sel;
    src2_sel_e             src2_sel;
    alu_op_e               alu_op;
    logic [`ID_GPR_AW-1:0] rd;
    logic                  gpr_wen;
    logic                  mem_ren;
    logic                  mem_wen;
    logic                  load_sel;
    logic                  invalid;
  } ds_to_es_t;

  typedef struct packed {
    logic                taken;
    logic [`ID_XLEN-1:0] target;
  } br_bus_t;

endpackage

/* rtl/inst_decoder.sv */
// unused source fields read as x0 so they never forward or stall; other encodings flag invalid
`timescale 1ns/1ns
`include "id_macros.svh"

module inst_decoder
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic [`ID_INST_W-1:0] i_inst,
  output dec_ctrl_t             o_ctrl
);

  opcode_e             opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`ID_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic                use_rs1;
  logic                use_rs2;
  logic                legal;

  assign opcode = opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{(`ID_XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(`ID_XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(`ID_XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7],
                  i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{(`ID_XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(`ID_XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12],
                  i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    o_ctrl          = '0;
    o_ctrl.rd       = i_inst[11:7];
    o_ctrl.alu_op   = ALU_ADD;
    o_ctrl.src1_sel = SRC1_RS1;
    o_ctrl.src2_sel = SRC2_IMM;
    o_ctrl.br_kind  = BR_NONE;
    o_ctrl.br_func  = br_func_e'(funct3);
    use_rs1         = 1'b1;
    use_rs2         = 1'b0;
    legal           = 1'b1;
    case (opcode)
      OPC_LUI: begin
        use_rs1        = 1'b0;
        o_ctrl.imm     = imm_u;
        o_ctrl.alu_op  = ALU_PASS2;
        o_ctrl.gpr_wen = 1'b1;
      end
      OPC_OP_IMM: begin
        legal          = (funct3 == 3'b000); // addi only
        o_ctrl.imm     = imm_i;
        o_ctrl.gpr_wen = 1'b1;
      end
      OPC_OP: begin
        legal           = (funct3 == 3'b000) && (funct7 == 7'b0000000 || funct7 == 7'b0100000);
        use_rs2         = 1'b1;
        o_ctrl.src2_sel = SRC2_RS2;
        o_ctrl.alu_op   = funct7[5] ? ALU_SUB : ALU_ADD;
        o_ctrl.gpr_wen  = 1'b1;
      end
      OPC_LOAD: begin
        legal           = (funct3 == 3'b011); // ld
        o_ctrl.imm      = imm_i;
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.mem_ren  = 1'b1;
        o_ctrl.load_sel = 1'b1;
      end
      OPC_STORE: begin
        legal          = (funct3 == 3'b011); // sd
        use_rs2        = 1'b1;
        o_ctrl.imm     = imm_s;
        o_ctrl.mem_wen = 1'b1;
      end
      OPC_BRANCH: begin
        legal          = (funct3[2:1] != 2'b01);
        use_rs2        = 1'b1;
        o_ctrl.imm     = imm_b;
        o_ctrl.br_kind = BR_COND;
      end
      OPC_JAL: begin
        use_rs1         = 1'b0;
        o_ctrl.imm      = imm_j;
        o_ctrl.src1_sel = SRC1_PC; // link value pc + 4
        o_ctrl.src2_sel = SRC2_FOUR;
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.br_kind  = BR_JAL;
      end
      OPC_JALR: begin
        legal           = (funct3 == 3'b000);
        o_ctrl.imm      = imm_i;
        o_ctrl.src1_sel = SRC1_PC;
        o_ctrl.src2_sel = SRC2_FOUR;
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.br_kind  = BR_JALR;
      end
      default: legal = 1'b0;
    endcase
    o_ctrl.rs1 = use_rs1 ? i_inst[19:15] : '0;
    o_ctrl.rs2 = use_rs2 ? i_inst[24:20] : '0;
    if (!legal) begin
      o_ctrl.invalid  = 1'b1;
      o_ctrl.gpr_wen  = 1'b0;
      o_ctrl.mem_ren  = 1'b0;
      o_ctrl.mem_wen  = 1'b0;
      o_ctrl.load_sel = 1'b0;
      o_ctrl.br_kind  = BR_NONE;
    end
  end

endmodule

/* rtl/gpr_file.sv */
// x0 hardwired to zero; a read in the write cycle returns the old value, bypass covers the rest
`timescale 1ns/1ns
`include "id_macros.svh"

module gpr_file
  import pipe_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic [`ID_GPR_AW-1:0] i_raddr1,
  input  logic [`ID_GPR_AW-1:0] i_raddr2,
  output logic [`ID_XLEN-1:0]   o_rdata1,
  output logic [`ID_XLEN-1:0]   o_rdata2,
  input  rf_wr_t                i_wr
);

  logic [`ID_XLEN-1:0] regs [1:31]; // no storage for x0

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 1; i < 32; i++) regs[i] <= '0;
    end else if (i_wr.wen && i_wr.addr != '0) begin
      regs[i_wr.addr] <= i_wr.data;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

/* rtl/operand_bypass.sv */
// priority execute > memory > writeback; a stage with rd zero is never a forwarding source
`timescale 1ns/1ns
`include "id_macros.svh"

module operand_bypass
  import pipe_pkg::*;
(
  input  logic [`ID_GPR_AW-1:0] i_rs1,
  input  logic [`ID_GPR_AW-1:0] i_rs2,
  input  logic [`ID_XLEN-1:0]   i_rf_rdata1,
  input  logic [`ID_XLEN-1:0]   i_rf_rdata2,
  input  bypass_t               i_es_bypass,
  input  bypass_t               i_ms_bypass,
  input  bypass_t               i_ws_bypass,
  output logic [`ID_XLEN-1:0]   o_rs1data,
  output logic [`ID_XLEN-1:0]   o_rs2data
);

  function automatic logic [`ID_XLEN-1:0] pick(
    input logic [`ID_GPR_AW-1:0] rs,
    input logic [`ID_XLEN-1:0]   rf_val
  );
    if (i_es_bypass.rd != '0 && i_es_bypass.rd == rs) return i_es_bypass.result;
    if (i_ms_bypass.rd != '0 && i_ms_bypass.rd == rs) return i_ms_bypass.result;
    if (i_ws_bypass.rd != '0 && i_ws_bypass.rd == rs) return i_ws_bypass.result;
    return rf_val;
  endfunction

  always_comb begin
    o_rs1data = pick(i_rs1, i_rf_rdata1);
    o_rs2data = pick(i_rs2, i_rf_rdata2);
  end

endmodule

/* rtl/branch_unit.sv */
// selection only; the caller decides whether the redirect differs from the fetch pc
`timescale 1ns/1ns
`include "id_macros.svh"

module branch_unit
  import isa_pkg::*;
(
  input  br_kind_e            i_kind,
  input  br_func_e            i_func,
  input  logic [`ID_XLEN-1:0] i_rs1data,
  input  logic [`ID_XLEN-1:0] i_rs2data,
  input  logic [`ID_XLEN-1:0] i_pc,
  input  logic [`ID_XLEN-1:0] i_imm,
  output logic                o_br_sel,
  output logic [`ID_XLEN-1:0] o_br_target
);

  logic                cond;
  logic [`ID_XLEN-1:0] jalr_sum;

  always_comb begin
    case (i_func)
      BR_BEQ:  cond = (i_rs1data == i_rs2data);
      BR_BNE:  cond = (i_rs1data != i_rs2data);
      BR_BLT:  cond = ($signed(i_rs1data) < $signed(i_rs2data));
      BR_BGE:  cond = ($signed(i_rs1data) >= $signed(i_rs2data));
      BR_BLTU: cond = (i_rs1data < i_rs2data);
      BR_BGEU: cond = (i_rs1data >= i_rs2data);
      default: cond = 1'b0;
    endcase
  end

  assign jalr_sum = i_rs1data + i_imm;

  always_comb begin
    o_br_sel    = 1'b0;
    o_br_target = i_pc + i_imm;
    case (i_kind)
      BR_COND: o_br_sel = cond;
      BR_JAL:  o_br_sel = 1'b1;
      BR_JALR: begin
        o_br_sel    = 1'b1;
        o_br_target = {jalr_sum[`ID_XLEN-1:1], 1'b0}; // lsb cleared
      end
      default: o_br_sel = 1'b0;
    endcase
  end

endmodule

/* rtl/id_stage.sv */
// single-entry decode stage; redirect is held back during a load-use stall so stale operands never steer fetch
`timescale 1ns/1ns
`include "id_macros.svh"

module id_stage
  import pipe_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  logic      i_fs_to_ds_valid,
  input  fs_to_ds_t i_fs_to_ds,
  output logic      o_ds_allowin,
  output logic      o_ds_to_es_valid,
  output ds_to_es_t o_ds_to_es,
  input  logic      i_es_allowin,
  output br_bus_t   o_br,
  input  rf_wr_t    i_ws_to_rf,
  input  bypass_t   i_es_bypass,
  input  bypass_t   i_ms_bypass,
  input  bypass_t   i_ws_bypass,
  input  logic      i_es_load_sel
);

  logic                ds_valid;
  logic                ds_ready_go;
  logic                load_stall;
  fs_to_ds_t           ds_r;   // held instruction and pc
  dec_ctrl_t           dec;
  logic [`ID_XLEN-1:0] rf_rdata1, rf_rdata2;
  logic [`ID_XLEN-1:0] rs1data, rs2data;
  logic                br_sel;
  logic [`ID_XLEN-1:0] br_target;

  // wait until the load reaches memory and can be forwarded from there
  assign load_stall = i_es_load_sel && (i_es_bypass.rd != '0) &&
                      (i_es_bypass.rd == dec.rs1 || i_es_bypass.rd == dec.rs2);

  assign ds_ready_go      = !load_stall;
  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) ds_valid <= 1'b0;
    else if (o_ds_allowin) ds_valid <= i_fs_to_ds_valid;
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && o_ds_allowin) begin
      ds_r.pc   <= i_fs_to_ds.pc;
      ds_r.inst <= o_br.taken ? `ID_NOP_INST : i_fs_to_ds.inst; // squash wrong-path fetch
    end
  end

  inst_decoder u_dec (
    .i_inst (ds_r.inst),
    .o_ctrl (dec)
  );

  gpr_file u_gpr (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_raddr1 (dec.rs1),
    .i_raddr2 (dec.rs2),
    .o_rdata1 (rf_rdata1),
    .o_rdata2 (rf_rdata2),
    .i_wr     (i_ws_to_rf)
  );

  operand_bypass u_byp (
    .i_rs1       (dec.rs1),
    .i_rs2       (dec.rs2),
    .i_rf_rdata1 (rf_rdata1),
    .i_rf_rdata2 (rf_rdata2),
    .i_es_bypass (i_es_bypass),
    .i_ms_bypass (i_ms_bypass),
    .i_ws_bypass (i_ws_bypass),
    .o_rs1data   (rs1data),
    .o_rs2data   (rs2data)
  );

  branch_unit u_bru (
    .i_kind      (dec.br_kind),
    .i_func      (dec.br_func),
    .i_rs1data   (rs1data),
    .i_rs2data   (rs2data),
    .i_pc        (ds_r.pc),
    .i_imm       (dec.imm),
    .o_br_sel    (br_sel),
    .o_br_target (br_target)
  );

  // no redirect when fetch is already at the target
  assign o_br.taken  = ds_valid && ds_ready_go && br_sel && (br_target != i_fs_to_ds.pc);
  assign o_br.target = br_target;

  always_comb begin
    o_ds_to_es.rs1data  = rs1data;
    o_ds_to_es.rs2data  = rs2data;
    o_ds_to_es.imm      = dec.imm;
    o_ds_to_es.pc       = ds_r.pc;
    o_ds_to_es.src1_sel = dec.src1_sel;
    o_ds_to_es.src2_sel = dec.src2_sel;
    o_ds_to_es.alu_op   = dec.alu_op;
    o_ds_to_es.rd       = dec.rd;
    o_ds_to_es.gpr_wen  = dec.gpr_wen;
    o_ds_to_es.mem_ren  = dec.mem_ren;
    o_ds_to_es.mem_wen  = dec.mem_wen;
    o_ds_to_es.load_sel = dec.load_sel;
    o_ds_to_es.invalid  = dec.invalid;
  end

endmodule

/* tests/tb_id_stage.sv */
// fetch, execute and writeback are modelled by the testbench; bypass results are fixed values
`timescale 1ns/1ns
`include "id_macros.svh"

module tb_id_stage
  import isa_pkg::*;
  import pipe_pkg::*;
;
  logic i_clk, i_rst_n, i_fs_to_ds_valid, i_es_allowin, i_es_load_sel;
  fs_to_ds_t i_fs_to_ds;
  rf_wr_t i_ws_to_rf;
  bypass_t i_es_bypass, i_ms_bypass, i_ws_bypass;
  logic o_ds_allowin, o_ds_to_es_valid;
  ds_to_es_t o_ds_to_es;
  br_bus_t o_br;

  logic [`ID_XLEN-1:0] shadow [0:31]; // register values the testbench wrote
  fs_to_ds_t held[$];                  // instructions expected inside the stage
  integer seed, errors, cycles, n_sent, n_out, j;
  ds_to_es_t exp_es;
  br_bus_t exp_br;
  logic exp_stall, exp_valid, exp_allowin;
  logic [3:0] inv_flags;
  logic [`ID_XLEN-1:0] a, c;
  logic [2:0] funcs [0:5];

  id_stage DUT (.*);

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  function automatic [31:0] enc_r(input [6:0] f7, input [4:0] rs2, rs1, rd);
    return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic [31:0] enc_i(input [11:0] imm, input [4:0] rs1, input [2:0] f3,
                                  input [4:0] rd, input [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic [31:0] enc_s(input [11:0] imm, input [4:0] rs2, rs1);
    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
  endfunction

  function automatic [31:0] enc_b(input [12:0] imm, input [4:0] rs2, rs1, input [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic [31:0] enc_j(input [20:0] imm, input [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // latest stage wins, rd zero carries nothing
  function automatic [`ID_XLEN-1:0] forward_value(input [4:0] rs);
    if (rs == 0) return '0;
    if (i_es_bypass.rd == rs) return i_es_bypass.result;
    if (i_ms_bypass.rd == rs) return i_ms_bypass.result;
    if (i_ws_bypass.rd == rs) return i_ws_bypass.result;
    return shadow[rs];
  endfunction

  function automatic void ref_decode(input [31:0] inst, input [63:0] pc, input [63:0] fpc,
                                     output ds_to_es_t e, output br_bus_t b, output logic st);
    logic [2:0] f3;
    logic [4:0] rs1, rs2;
    logic u1, u2, ok, sel, cond;
    logic [1:0] kind; // 0 none, 1 cond, 2 jal, 3 jalr
    logic [63:0] tgt;
    f3 = inst[14:12];
    e = '0;
    e.pc = pc;
    e.rd = inst[11:7];
    e.src2_sel = SRC2_IMM;
    u1 = 1'b1;
    u2 = 1'b0;
    ok = 1'b1;
    kind = 2'd0;
    case (inst[6:0])
      7'b0110111: begin
        u1 = 1'b0;
        e.imm = {{32{inst[31]}}, inst[31:12], 12'b0};
        e.alu_op = ALU_PASS2;
        e.gpr_wen = 1'b1;
      end
      7'b0010011: begin
        ok = (f3 == 3'b000);
        e.imm = {{52{inst[31]}}, inst[31:20]};
        e.gpr_wen = 1'b1;
      end
      7'b0110011: begin
        ok = (f3 == 3'b000) && (inst[31:25] == 7'h00 || inst[31:25] == 7'h20);
        u2 = 1'b1;
        e.src2_sel = SRC2_RS2;
        e.alu_op = inst[30] ? ALU_SUB : ALU_ADD;
        e.gpr_wen = 1'b1;
      end
      7'b0000011: begin
        ok = (f3 == 3'b011);
        e.imm = {{52{inst[31]}}, inst[31:20]};
        e.gpr_wen = 1'b1;
        e.mem_ren = 1'b1;
        e.load_sel = 1'b1;
      end
      7'b0100011: begin
        ok = (f3 == 3'b011);
        u2 = 1'b1;
        e.imm = {{52{inst[31]}}, inst[31:25], inst[11:7]};
        e.mem_wen = 1'b1;
      end
      7'b1100011: begin
        ok = (f3 != 3'b010) && (f3 != 3'b011);
        u2 = 1'b1;
        e.imm = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        kind = 2'd1;
      end
      7'b1101111: begin
        u1 = 1'b0;
        e.imm = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        e.src1_sel = SRC1_PC;
        e.src2_sel = SRC2_FOUR;
        e.gpr_wen = 1'b1;
        kind = 2'd2;
      end
      7'b1100111: begin
        ok = (f3 == 3'b000);
        e.imm = {{52{inst[31]}}, inst[31:20]};
        e.src1_sel = SRC1_PC;
        e.src2_sel = SRC2_FOUR;
        e.gpr_wen = 1'b1;
        kind = 2'd3;
      end
      default: ok = 1'b0;
    endcase
    if (!ok) begin
      e.invalid = 1'b1;
      e.gpr_wen = 1'b0;
      e.mem_ren = 1'b0;
      e.mem_wen = 1'b0;
      e.load_sel = 1'b0;
      kind = 2'd0;
    end
    rs1 = u1 ? inst[19:15] : 5'd0;
    rs2 = u2 ? inst[24:20] : 5'd0;
    e.rs1data = forward_value(rs1);
    e.rs2data = forward_value(rs2);
    st = i_es_load_sel && i_es_bypass.rd != 0 &&
         (i_es_bypass.rd == rs1 || i_es_bypass.rd == rs2);
    case (f3)
      3'b000: cond = e.rs1data == e.rs2data;
      3'b001: cond = e.rs1data != e.rs2data;
      3'b100: cond = $signed(e.rs1data) < $signed(e.rs2data);
      3'b101: cond = $signed(e.rs1data) >= $signed(e.rs2data);
      3'b110: cond = e.rs1data < e.rs2data;
      default: cond = e.rs1data >= e.rs2data;
    endcase
    sel = (kind == 2'd1) ? cond : (kind != 2'd0);
    tgt = (kind == 2'd3) ? ((e.rs1data + e.imm) & ~64'd1) : pc + e.imm;
    b.taken = sel && !st && tgt != fpc;
    b.target = tgt;
  endfunction

  task automatic flag_value(input string name, input [319:0] got, input [319:0] exp);
    $display("** Error: %s = %h, expected %h", name, got, exp);
    errors++;
  endtask

  // comparison against the model on every rising edge
  always @(posedge i_clk) begin
    if (i_rst_n) begin
      exp_stall = 1'b0;
      exp_br = '0;
      if (held.size() > 0)
        ref_decode(held[0].inst, held[0].pc, i_fs_to_ds.pc, exp_es, exp_br, exp_stall);
      exp_valid = held.size() > 0 && !exp_stall;
      exp_allowin = held.size() == 0 || (!exp_stall && i_es_allowin);
      inv_flags = {o_ds_to_es.invalid, o_ds_to_es.gpr_wen, o_ds_to_es.mem_ren,
                   o_ds_to_es.mem_wen};
      if (o_ds_to_es_valid != exp_valid)
        flag_value("o_ds_to_es_valid", o_ds_to_es_valid, exp_valid);
      if (o_ds_allowin != exp_allowin)
        flag_value("o_ds_allowin", o_ds_allowin, exp_allowin);
      if (o_br.taken != (exp_valid && exp_br.taken))
        flag_value("o_br.taken", o_br.taken, exp_br.taken);
      if (exp_valid && exp_br.taken && o_br.target != exp_br.target)
        flag_value("o_br.target", o_br.target, exp_br.target);
      if (exp_valid && !exp_es.invalid && o_ds_to_es != exp_es)
        flag_value("o_ds_to_es", o_ds_to_es, exp_es);
      if (exp_valid && exp_es.invalid && inv_flags != 4'b1000)
        flag_value("o_ds_to_es.invalid/wen/ren", inv_flags, 4'b1000);
      if (o_ds_to_es_valid && i_es_allowin)
        n_out++;
      if (exp_valid && i_es_allowin)
        void'(held.pop_front());
      if (i_fs_to_ds_valid && exp_allowin) // squash when redirecting this cycle
        held.push_back({(exp_valid && exp_br.taken) ? `ID_NOP_INST : i_fs_to_ds.inst,
                        i_fs_to_ds.pc});
      if (i_ws_to_rf.wen && i_ws_to_rf.addr != 0) shadow[i_ws_to_rf.addr] = i_ws_to_rf.data;
    end
  end

  always @(posedge i_clk) begin
    cycles++;
    if (cycles >= 2000) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic wr_reg(input [4:0] idx, input [63:0] val);
    @(negedge i_clk);
    i_ws_to_rf = {1'b1, idx, val};
    @(negedge i_clk);
    i_ws_to_rf = '0;
  endtask

  // waits for acceptance, leaves fetch valid high for chaining
  task automatic send(input [31:0] inst, input [63:0] pc);
    @(negedge i_clk);
    i_fs_to_ds_valid = 1'b1;
    i_fs_to_ds = {inst, pc};
    do @(posedge i_clk); while (!o_ds_allowin);
    n_sent++;
  endtask

  task automatic stop_fetch();
    @(negedge i_clk);
    i_fs_to_ds_valid = 1'b0;
  endtask

  task automatic drain();
    do @(negedge i_clk); while (held.size() > 0);
  endtask

  initial begin
    seed = 32'hf0ff;
    errors = 0;
    cycles = 0;
    n_sent = 0;
    n_out = 0;
    funcs = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    for (j = 0; j < 32; j++) shadow[j] = '0;
    i_rst_n = 1'b0;
    i_fs_to_ds_valid = 1'b0;
    i_fs_to_ds = '0;
    i_es_allowin = 1'b1;
    i_es_load_sel = 1'b0;
    i_ws_to_rf = '0;
    i_es_bypass = '0;
    i_ms_bypass = '0;
    i_ws_bypass = '0;
    repeat (3) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;
    if (!o_ds_allowin || o_ds_to_es_valid || o_br.taken) begin
      $display("after reset the stage is not empty and ready");
      errors++;
    end
    for (j = 1; j <= 10; j++) wr_reg(j, {$random(seed), $random(seed)});
    send(enc_r(7'h00, 5'd2, 5'd1, 5'd11), 64'h100);
    send(enc_r(7'h20, 5'd4, 5'd3, 5'd12), 64'h104);
    send(enc_i(12'hff9, 5'd5, 3'b000, 5'd13, 7'b0010011), 64'h108);
    send({20'hfffff, 5'd14, 7'b0110111}, 64'h10c);
    send(enc_i(12'h010, 5'd6, 3'b011, 5'd15, 7'b0000011), 64'h110);
    send(enc_s(12'hff8, 5'd7, 5'd8), 64'h114);
    stop_fetch();
    drain();
    // forwarding priority, held by back-pressure
    i_es_allowin = 1'b0;
    send(enc_r(7'h00, 5'd4, 5'd3, 5'd9), 64'h200);
    stop_fetch();
    i_es_bypass = {5'd3, 64'h1111};
    i_ms_bypass = {5'd3, 64'h2222};
    i_ws_bypass = {5'd3, 64'h3333};
    repeat (2) @(negedge i_clk);
    i_es_bypass = {5'd0, 64'h4444};
    repeat (2) @(negedge i_clk);
    i_ms_bypass = '0;
    repeat (2) @(negedge i_clk);
    i_ws_bypass = '0;
    i_es_allowin = 1'b1;
    drain();
    // load-use stall
    i_es_bypass = {5'd4, 64'h5555};
    i_es_load_sel = 1'b1;
    send(enc_r(7'h00, 5'd4, 5'd1, 5'd10), 64'h300);
    stop_fetch();
    repeat (2) @(negedge i_clk);
    if (o_ds_to_es_valid || o_ds_allowin) begin
      $display("load-use stall did not block the stage");
      errors++;
    end
    i_es_load_sel = 1'b0;
    i_es_bypass = '0;
    i_ms_bypass = {5'd4, 64'h6666};
    drain();
    i_ms_bypass = '0;
    // back-pressure with a second instruction waiting
    i_es_allowin = 1'b0;
    send(enc_i(12'h001, 5'd1, 3'b000, 5'd2, 7'b0010011), 64'h400);
    fork
      send(enc_i(12'h002, 5'd2, 3'b000, 5'd3, 7'b0010011), 64'h404);
      begin
        repeat (4) @(negedge i_clk);
        i_es_allowin = 1'b1;
      end
    join
    stop_fetch();
    drain();
    // branches, each followed by the fall-through fetch
    for (j = 0; j < 12; j++) begin
      a = {$random(seed), $random(seed)};
      c = (j >= 6) ? a : {$random(seed), $random(seed)};
      wr_reg(5'd6, a);
      wr_reg(5'd7, c);
      send(enc_b(13'h040, 5'd7, 5'd6, funcs[j % 6]), 64'h1000 + j * 64);
      send(enc_i(12'h005, 5'd2, 3'b000, 5'd1, 7'b0010011), 64'h1004 + j * 64);
      stop_fetch();
      drain();
    end
    send(enc_j(21'h000100, 5'd1), 64'h2000);
    send(enc_i(12'h005, 5'd2, 3'b000, 5'd1, 7'b0010011), 64'h2004);
    send(enc_i(12'h009, 5'd6, 3'b000, 5'd1, 7'b1100111), 64'h2008);
    send(enc_i(12'h005, 5'd2, 3'b000, 5'd1, 7'b0010011), 64'h200c);
    // outside the subset
    send(32'h00000007, 64'h3000);
    send(enc_r(7'h01, 5'd2, 5'd1, 5'd3), 64'h3004);
    send(enc_b(13'h040, 5'd2, 5'd1, 3'b010), 64'h3008);
    stop_fetch();
    drain();
    if (n_out != n_sent) begin
      $display("instruction count mismatch: %0d sent, %0d passed to execute", n_sent, n_out);
      errors++;
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+rtl
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/inst_decoder.sv
rtl/gpr_file.sv
rtl/operand_bypass.sv
rtl/branch_unit.sv
rtl/id_stage.sv
tests/tb_id_stage.sv

/* run.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_id_stage -o sim_id_stage \
  && ./obj_dir/sim_id_stage > sim.log 2>&1
grep -q "Simulation PASSED" sim.log && echo "run passed" || { echo "run failed"; exit 1; }
